/* all.f */
+incdir+include
hdl/axi_read_pkg.sv
hdl/layer_pkg.sv
hdl/window_sequencer.sv
hdl/row_fetch.sv
hdl/window_stream.sv
hdl/input_layer_top.sv
testbench/tb_clock.sv
testbench/ddr_read_model.sv
testbench/input_layer_chk.sv
testbench/tb_input_layer.sv

/* run_sim.sh */
#!/bin/sh
# build and run the input layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_input_layer \
	-f all.f \
	-o tb_input_layer_sim

# the log decides the result, so a failing run must not stop the script here
./obj_dir/tb_input_layer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* testbench/tb_input_layer.sv */
// ----------------------------------------------------------
// testbench for the input layer window streamer
// each table entry runs one full frame; windows are compared
// against the DDR model's bytes with zero padding applied
// outputs are sampled on the falling edge
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "input_layer_cfg.svh"

module tb_input_layer;
	import axi_read_pkg::*;
	import layer_pkg::*;

	typedef struct packed {
		axi_addr_t base;
		dim_t      layers;
		dim_t      rows;
		dim_t      cols;
		axi_addr_t stride;
		logic      backpressure;
		logic      restart;
	} test_entry_t;

	localparam int NUM_TESTS = 5;

	logic        clk;
	logic        reset_n;
	logic        start;
	axi_addr_t   base_addr;
	dim_t        num_layers;
	dim_t        num_rows;
	dim_t        num_cols;
	axi_addr_t   row_stride;
	axi_addr_t   ar_addr;
	axi_len_t    ar_len;
	logic        ar_valid;
	logic        ar_ready;
	axi_data_t   r_data;
	logic        r_valid;
	logic        r_last;
	logic        r_ready;
	window_t     window_data;
	logic        window_valid;
	logic        window_ready;
	dim_t        window_layer;
	logic        read_done;

	test_entry_t tests [NUM_TESTS];
	int          cur_base;
	int          cur_stride;
	int          cur_rows;
	int          cur_cols;
	logic [31:0] ready_rng = 32'hea99_2469;

	tb_clock u_tb_clock (
		.clk     (clk),
		.reset_n (reset_n)
	);

	ddr_read_model u_ddr (
		.clk      (clk),
		.reset_n  (reset_n),
		.ar_addr  (ar_addr),
		.ar_len   (ar_len),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r_data   (r_data),
		.r_valid  (r_valid),
		.r_last   (r_last),
		.r_ready  (r_ready)
	);

	input_layer_top u_input_layer_top (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (start),
		.base_addr    (base_addr),
		.num_layers   (num_layers),
		.num_rows     (num_rows),
		.num_cols     (num_cols),
		.row_stride   (row_stride),
		.ar_addr      (ar_addr),
		.ar_len       (ar_len),
		.ar_valid     (ar_valid),
		.ar_ready     (ar_ready),
		.r_data       (r_data),
		.r_valid      (r_valid),
		.r_last       (r_last),
		.r_ready      (r_ready),
		.window_data  (window_data),
		.window_valid (window_valid),
		.window_ready (window_ready),
		.window_layer (window_layer),
		.read_done    (read_done)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// feature byte of layer l at row y, column x; zero outside the map
	function automatic pixel_t pixel_at(input int l, input int y, input int x);
		int addr;
		if (y < 0 || y >= cur_rows || x < 0 || x >= cur_cols)
			return 8'h00;
		addr = cur_base + l * 4096 + y * cur_stride + x;
		return u_ddr.mem[16'(addr)];
	endfunction

	function automatic window_t expected_window(input int l, input int r, input int c);
		window_t w;
		w = '0;
		for (int i = 0; i < 3; i++)
			for (int j = 0; j < 3; j++)
				w[(3 * i + j) * 8 +: 8] = pixel_at(l, r + i - 1, c + j - 1);
		return w;
	endfunction

	task automatic check_value(input string what, input logic [71:0] actual,
			input logic [71:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "value mismatch on %s", what);
		end
	endtask

	// ------------------------------------------------------------
	// one frame: start, collect windows in row, layer, column order
	// ------------------------------------------------------------
	task automatic run_entry(input int k);
		int        win_cnt;
		int        total;
		int        layers;
		int        row;
		int        layer;
		int        col;
		int        exp_len;
		logic      done_seen;
		logic      poked;
		axi_addr_t exp_addr [$];
		cur_base   = int'(tests[k].base);
		cur_stride = int'(tests[k].stride);
		cur_rows   = int'(tests[k].rows);
		cur_cols   = int'(tests[k].cols);
		layers     = int'(tests[k].layers);
		total      = cur_rows * layers * cur_cols;
		exp_len    = (cur_cols + 15) / 16 - 1;
		win_cnt    = 0;
		row        = 0;
		layer      = 0;
		col        = 0;
		done_seen  = 1'b0;
		poked      = 1'b0;
		// one burst per source row inside the map, in fetch order
		for (int r = 0; r < cur_rows; r++)
			for (int l = 0; l < layers; l++)
				for (int y = r - 1; y <= r + 1; y++)
					if (y >= 0 && y < cur_rows)
						exp_addr.push_back(axi_addr_t'(cur_base + l * 4096 +
							y * cur_stride));
		@(posedge clk);
		base_addr    <= tests[k].base;
		num_layers   <= tests[k].layers;
		num_rows     <= tests[k].rows;
		num_cols     <= tests[k].cols;
		row_stride   <= tests[k].stride;
		window_ready <= 1'b1;
		start        <= 1'b1;
		while (!done_seen) begin
			@(negedge clk);
			if (ar_valid && ar_ready) begin
				check_value("ar_len", 72'(ar_len), 72'(exp_len));
				check_value("burst beyond the expected count",
					72'(exp_addr.size() == 0), 72'd0);
				check_value("ar_addr", 72'(ar_addr), 72'(exp_addr.pop_front()));
			end
			// no back-pressure on the read data channel
			if (r_valid)
				check_value("r_ready", 72'(r_ready), 72'd1);
			if (window_valid && window_ready) begin
				check_value("window_layer", 72'(window_layer), 72'(layer));
				check_value("window_data", window_data, expected_window(layer, row, col));
				win_cnt++;
				col++;
				if (col == cur_cols) begin
					col = 0;
					layer++;
					if (layer == layers) begin
						layer = 0;
						row++;
					end
				end
			end
			if (read_done) begin
				done_seen = 1'b1;
				check_value("windows before read_done", 72'(win_cnt), 72'(total));
				check_value("bursts not issued", 72'(exp_addr.size()), 72'd0);
			end
			@(posedge clk);
			start <= 1'b0;
			ready_rng = next_random(ready_rng);
			window_ready <= tests[k].backpressure ? ready_rng[16] : 1'b1;
			// a second start in mid-frame with another geometry must be ignored
			if (tests[k].restart && !poked && win_cnt == 2) begin
				start     <= 1'b1;
				base_addr <= tests[k].base ^ 32'h0000_1000;
				num_cols  <= 10'd1;
				poked     = 1'b1;
			end
		end
		repeat (3) begin
			@(negedge clk);
			check_value("read_done after frame end", 72'(read_done), 72'd0);
		end
	endtask

	initial begin
		// base, layers, rows, cols, stride, back-pressure, restart
		tests[0] = '{32'h0000_0000, 10'd1, 10'd1, 10'd16, 32'd16, 1'b0, 1'b0};
		tests[1] = '{32'h0000_1000, 10'd3, 10'd4, 10'd20, 32'd32, 1'b0, 1'b0};
		tests[2] = '{32'h0000_4000, 10'd1, 10'd2, 10'd64, 32'd128, 1'b0, 1'b0};
		tests[3] = '{32'h0000_5000, 10'd2, 10'd3, 10'd40, 32'd48, 1'b1, 1'b0};
		tests[4] = '{32'h0000_8000, 10'd2, 10'd2, 10'd7, 32'd16, 1'b1, 1'b1};
		start        <= 1'b0;
		base_addr    <= '0;
		num_layers   <= '0;
		num_rows     <= '0;
		num_cols     <= '0;
		row_stride   <= '0;
		window_ready <= 1'b0;
		@(posedge reset_n);
		for (int k = 0; k < NUM_TESTS; k++)
			run_entry(k);
		$display(">>> PASS");
		$finish;
	end

	// watchdog, budget from the table with margin for bus stalls
	initial begin : watchdog
		int limit;
		@(posedge reset_n);
		limit = 200;
		for (int k = 0; k < NUM_TESTS; k++)
			limit += int'(tests[k].rows) * int'(tests[k].layers) *
			         (int'(tests[k].cols) + 3 * 40) * 4;
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run hung", limit);
		$display(">>> FAIL");
		$fatal(1, "timeout");
	end

endmodule

/* testbench/input_layer_chk.sv */
// ----------------------------------------------------------
// protocol assertions, bound to the top level
// ----------------------------------------------------------
`timescale 1ns/1ns

module input_layer_chk (
	input logic                    clk,
	input logic                    reset_n,
	input axi_read_pkg::axi_addr_t ar_addr,
	input axi_read_pkg::axi_len_t  ar_len,
	input logic                    ar_valid,
	input logic                    ar_ready,
	input layer_pkg::window_t      window_data,
	input logic                    window_valid,
	input logic                    window_ready,
	input layer_pkg::dim_t         window_layer,
	input logic                    read_done
);

	// address channel holds until accepted
	a_ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
		else $error("ar_valid, ar_addr or ar_len changed before ar_ready");

	a_window_hold: assert property (@(posedge clk) disable iff (!reset_n)
		window_valid && !window_ready |=>
			window_valid && $stable(window_data) && $stable(window_layer))
		else $error("window changed or dropped while window_ready was low");

	a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		read_done |=> !read_done)
		else $error("read_done high for two cycles in a row");

	a_reset_valid: assert property (@(posedge clk) !reset_n |=> !window_valid)
		else $error("window_valid high in the cycle after reset");

endmodule

bind input_layer_top input_layer_chk u_input_layer_chk (
	.clk          (clk),
	.reset_n      (reset_n),
	.ar_addr      (ar_addr),
	.ar_len       (ar_len),
	.ar_valid     (ar_valid),
	.ar_ready     (ar_ready),
	.window_data  (window_data),
	.window_valid (window_valid),
	.window_ready (window_ready),
	.window_layer (window_layer),
	.read_done    (read_done)
);

/* testbench/ddr_read_model.sv */
// ----------------------------------------------------------
// DDR read model, 64 KiB byte array behind an AXI read port
// only the low 16 address bits are decoded
// one burst at a time; every beat is followed by a gap and
// may be stalled further at random
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "input_layer_cfg.svh"

module ddr_read_model (
	input  logic                    clk,
	input  logic                    reset_n,
	input  axi_read_pkg::axi_addr_t ar_addr,
	input  axi_read_pkg::axi_len_t  ar_len,
	input  logic                    ar_valid,
	output logic                    ar_ready,
	output axi_read_pkg::axi_data_t r_data,
	output logic                    r_valid,
	output logic                    r_last,
	input  logic                    r_ready
);
	import axi_read_pkg::*;

	logic [7:0]  mem [0:65535];
	logic [31:0] stall_rng = 32'hea99_2469;
	logic        ar_ready_q = 1'b0;
	logic        r_valid_q = 1'b0;
	logic        r_last_q = 1'b0;
	axi_data_t   r_data_q = '0;
	logic        busy = 1'b0;
	axi_addr_t   burst_addr;
	axi_len_t    burst_len;
	axi_len_t    beat;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// little-endian beat, byte 0 in the low bits
	function automatic axi_data_t beat_data(input axi_addr_t a);
		axi_data_t d;
		for (int b = 0; b < `BEAT_BYTES; b++)
			d[b * 8 +: 8] = mem[16'(a + axi_addr_t'(b))];
		return d;
	endfunction

	initial begin : fill
		logic [31:0] s;
		s = 32'hea99_2469;
		for (int a = 0; a < 65536; a++) begin
			s = next_random(s);
			mem[a] = s[23:16];
		end
	end

	assign ar_ready = ar_ready_q;
	assign r_valid  = r_valid_q;
	assign r_last   = r_last_q;
	assign r_data   = r_data_q;

	always @(posedge clk) begin
		stall_rng <= next_random(stall_rng);
		if (!reset_n) begin
			ar_ready_q <= 1'b0;
			r_valid_q  <= 1'b0;
			r_last_q   <= 1'b0;
			busy       <= 1'b0;
		end else if (!busy) begin
			if (ar_valid && ar_ready_q) begin
				busy       <= 1'b1;
				burst_addr <= ar_addr;
				burst_len  <= ar_len;
				beat       <= '0;
				ar_ready_q <= 1'b0;
			end else begin
				ar_ready_q <= stall_rng[15];
			end
		end else if (r_valid_q && r_ready) begin
			r_valid_q <= 1'b0;
			r_last_q  <= 1'b0;
			if (beat == burst_len)
				busy <= 1'b0;
			else
				beat <= beat + axi_len_t'(1);
		end else if (!r_valid_q && stall_rng[14]) begin
			r_valid_q <= 1'b1;
			r_data_q  <= beat_data(burst_addr + (axi_addr_t'(beat) << 4));
			r_last_q  <= (beat == burst_len);
		end
	end

endmodule

/* testbench/tb_clock.sv */
// ----------------------------------------------------------
// testbench clock and reset source
// clk period is 40 ns; reset_n is held low for 10 cycles
// ----------------------------------------------------------
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic reset_n
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		reset_n = 1'b0;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
	end

endmodule

/* hdl/input_layer_top.sv */
// ----------------------------------------------------------
// input layer window streamer, top level
// reads feature maps over an AXI read channel and emits
// zero-padded 3x3 windows ordered by row, layer, column
// base_addr must be 4 KiB aligned, row_stride a multiple of
// 16 and at least the row size, num_cols 1 to 64
// ----------------------------------------------------------
`timescale 1ns/1ns

module input_layer_top (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    start,
	input  axi_read_pkg::axi_addr_t base_addr,
	input  layer_pkg::dim_t         num_layers,
	input  layer_pkg::dim_t         num_rows,
	input  layer_pkg::dim_t         num_cols,
	input  axi_read_pkg::axi_addr_t row_stride,
	output axi_read_pkg::axi_addr_t ar_addr,
	output axi_read_pkg::axi_len_t  ar_len,
	output logic                    ar_valid,
	input  logic                    ar_ready,
	input  axi_read_pkg::axi_data_t r_data,
	input  logic                    r_valid,
	input  logic                    r_last,
	output logic                    r_ready,
	output layer_pkg::window_t      window_data,
	output logic                    window_valid,
	input  logic                    window_ready,
	output layer_pkg::dim_t         window_layer,
	output logic                    read_done
);
	import axi_read_pkg::*;
	import layer_pkg::*;

	// sequencer to fetcher
	logic      fetch_req;
	dim_t      fetch_layer;
	dim_t      fetch_row;
	row_slot_t fetch_slot;
	logic      fetch_pad;
	logic      fetch_done;
	axi_addr_t cfg_base;
	axi_addr_t cfg_stride;
	dim_t      cfg_cols;

	// fetcher to stream
	logic      buf_we;
	row_slot_t buf_slot;
	beat_idx_t buf_beat;
	axi_data_t buf_data;

	// sequencer to stream
	logic      stream_go;
	logic      row_streamed;

	window_sequencer u_window_sequencer (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (start),
		.base_addr    (base_addr),
		.num_layers   (num_layers),
		.num_rows     (num_rows),
		.num_cols     (num_cols),
		.row_stride   (row_stride),
		.fetch_done   (fetch_done),
		.row_streamed (row_streamed),
		.fetch_req    (fetch_req),
		.fetch_layer  (fetch_layer),
		.fetch_row    (fetch_row),
		.fetch_slot   (fetch_slot),
		.fetch_pad    (fetch_pad),
		.cfg_base     (cfg_base),
		.cfg_stride   (cfg_stride),
		.cfg_cols     (cfg_cols),
		.stream_go    (stream_go),
		.window_layer (window_layer),
		.read_done    (read_done)
	);

	row_fetch u_row_fetch (
		.clk         (clk),
		.reset_n     (reset_n),
		.fetch_req   (fetch_req),
		.fetch_layer (fetch_layer),
		.fetch_row   (fetch_row),
		.fetch_slot  (fetch_slot),
		.fetch_pad   (fetch_pad),
		.cfg_base    (cfg_base),
		.cfg_stride  (cfg_stride),
		.cfg_cols    (cfg_cols),
		.ar_ready    (ar_ready),
		.r_data      (r_data),
		.r_valid     (r_valid),
		.r_last      (r_last),
		.ar_addr     (ar_addr),
		.ar_len      (ar_len),
		.ar_valid    (ar_valid),
		.r_ready     (r_ready),
		.buf_we      (buf_we),
		.buf_slot    (buf_slot),
		.buf_beat    (buf_beat),
		.buf_data    (buf_data),
		.fetch_done  (fetch_done)
	);

	window_stream u_window_stream (
		.clk          (clk),
		.reset_n      (reset_n),
		.buf_we       (buf_we),
		.buf_slot     (buf_slot),
		.buf_beat     (buf_beat),
		.buf_data     (buf_data),
		.stream_go    (stream_go),
		.cfg_cols     (cfg_cols),
		.window_ready (window_ready),
		.window_data  (window_data),
		.window_valid (window_valid),
		.row_streamed (row_streamed)
	);

endmodule

/* hdl/window_stream.sv */
// ----------------------------------------------------------
// three-row buffer and 3x3 window output stage
// the buffer is only written while no row is streaming, so
// window_data is built straight from it and held by the
// column counter under back-pressure
// columns outside 0..num_cols-1 read as zero
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "input_layer_cfg.svh"

module window_stream (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    buf_we,
	input  layer_pkg::row_slot_t    buf_slot,
	input  layer_pkg::beat_idx_t    buf_beat,
	input  axi_read_pkg::axi_data_t buf_data,
	input  logic                    stream_go,
	input  layer_pkg::dim_t         cfg_cols,
	input  logic                    window_ready,
	output layer_pkg::window_t      window_data,
	output logic                    window_valid,
	output logic                    row_streamed
);
	import axi_read_pkg::*;
	import layer_pkg::*;

	// slot 0 above, 1 centre, 2 below
	axi_data_t row_mem [3][`MAX_ROW_BEATS];
	dim_t      col_cnt;
	logic      accept;

	// ------------------------------------------------------
	// row buffer, written beat by beat
	// ------------------------------------------------------
	always_ff @(posedge clk) begin
		if (buf_we)
			row_mem[buf_slot][buf_beat] <= buf_data;
	end

	// ------------------------------------------------------
	// window assembly
	// ------------------------------------------------------
	always_comb begin : assemble
		dim_t      x;
		beat_idx_t beat;
		pixel_t    pix;
		window_data = '0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				// col 0, j 0 wraps to a large value and pads too
				x    = col_cnt + dim_t'(j) - dim_t'(1);
				beat = beat_idx_t'(x / dim_t'(`BEAT_BYTES));
				pix  = row_mem[i][beat][(x % dim_t'(`BEAT_BYTES)) * 8 +: 8];
				if (x < cfg_cols)
					window_data[(3 * i + j) * 8 +: 8] = pix;
			end
		end
	end

	assign accept = window_valid && window_ready;

	// ------------------------------------------------------
	// column walk and valid hold
	// ------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			window_valid <= 1'b0;
			row_streamed <= 1'b0;
			col_cnt      <= '0;
		end else begin
			row_streamed <= 1'b0;
			if (stream_go) begin
				window_valid <= 1'b1;
				col_cnt      <= '0;
			end else if (accept) begin
				if (col_cnt == cfg_cols - dim_t'(1)) begin
					window_valid <= 1'b0;
					row_streamed <= 1'b1;
				end else begin
					col_cnt <= col_cnt + dim_t'(1);
				end
			end
		end
	end

endmodule

/* hdl/row_fetch.sv */
// ----------------------------------------------------------
// fetches one source row per request as a single read burst
// padded rows are zero-filled over all beats instead, so no
// stale data stays in the row buffer
// rows must fit in MAX_ROW_BEATS beats; r_ready is never
// deasserted during a data phase
// ----------------------------------------------------------
`timescale 1ns/1ns
`include "input_layer_cfg.svh"

module row_fetch (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    fetch_req,
	input  layer_pkg::dim_t         fetch_layer,
	input  layer_pkg::dim_t         fetch_row,
	input  layer_pkg::row_slot_t    fetch_slot,
	input  logic                    fetch_pad,
	input  axi_read_pkg::axi_addr_t cfg_base,
	input  axi_read_pkg::axi_addr_t cfg_stride,
	input  layer_pkg::dim_t         cfg_cols,
	input  logic                    ar_ready,
	input  axi_read_pkg::axi_data_t r_data,
	input  logic                    r_valid,
	input  logic                    r_last,
	output axi_read_pkg::axi_addr_t ar_addr,
	output axi_read_pkg::axi_len_t  ar_len,
	output logic                    ar_valid,
	output logic                    r_ready,
	output logic                    buf_we,
	output layer_pkg::row_slot_t    buf_slot,
	output layer_pkg::beat_idx_t    buf_beat,
	output axi_read_pkg::axi_data_t buf_data,
	output logic                    fetch_done
);
	import axi_read_pkg::*;
	import layer_pkg::*;

	fetch_state_t state;
	axi_addr_t    addr_q;
	axi_len_t     len_q;
	row_slot_t    slot_q;
	beat_idx_t    beat_cnt;
	logic         beat_take;

	assign beat_take = (state == FET_DATA) && r_valid;

	// ------------------------------------------------------
	// burst request, held until the address phase completes
	// ------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == FET_IDLE && fetch_req) begin
			addr_q <= cfg_base + (axi_addr_t'(fetch_layer) << `LAYER_SHIFT) +
			          axi_addr_t'(fetch_row) * cfg_stride;
			// beats covering the row, minus one
			len_q  <= axi_len_t'((cfg_cols - dim_t'(1)) / dim_t'(`BEAT_BYTES));
			slot_q <= fetch_slot;
		end
	end

	// ------------------------------------------------------
	// fetch FSM
	// ------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state      <= FET_IDLE;
			beat_cnt   <= '0;
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= 1'b0;
			case (state)
				FET_IDLE: begin
					if (fetch_req) begin
						beat_cnt <= '0;
						state    <= fetch_pad ? FET_ZERO : FET_ADDR;
					end
				end
				FET_ADDR: begin
					if (ar_ready)
						state <= FET_DATA;
				end
				FET_DATA: begin
					if (r_valid) begin
						beat_cnt <= beat_cnt + beat_idx_t'(1);
						if (r_last) begin
							fetch_done <= 1'b1;
							state      <= FET_IDLE;
						end
					end
				end
				FET_ZERO: begin
					beat_cnt <= beat_cnt + beat_idx_t'(1);
					if (beat_cnt == beat_idx_t'(`MAX_ROW_BEATS - 1)) begin
						fetch_done <= 1'b1;
						state      <= FET_IDLE;
					end
				end
				default: state <= FET_IDLE;
			endcase
		end
	end

	assign ar_valid = (state == FET_ADDR);
	assign ar_addr  = addr_q;
	assign ar_len   = len_q;
	assign r_ready  = (state == FET_DATA);

	// row buffer write port
	assign buf_we   = beat_take || (state == FET_ZERO);
	assign buf_slot = slot_q;
	assign buf_beat = beat_cnt;
	assign buf_data = (state == FET_ZERO) ? '0 : r_data;

endmodule

/* hdl/window_sequencer.sv */
// ----------------------------------------------------------
// walks output rows, then layers, then the three row slots
// configuration is latched at start; start is ignored unless
// idle. fetch and streaming of a row set never overlap
// ----------------------------------------------------------
`timescale 1ns/1ns

module window_sequencer (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   start,
	input  axi_read_pkg::axi_addr_t base_addr,
	input  layer_pkg::dim_t        num_layers,
	input  layer_pkg::dim_t        num_rows,
	input  layer_pkg::dim_t        num_cols,
	input  axi_read_pkg::axi_addr_t row_stride,
	input  logic                   fetch_done,
	input  logic                   row_streamed,
	output logic                   fetch_req,
	output layer_pkg::dim_t        fetch_layer,
	output layer_pkg::dim_t        fetch_row,
	output layer_pkg::row_slot_t   fetch_slot,
	output logic                   fetch_pad,
	output axi_read_pkg::axi_addr_t cfg_base,
	output axi_read_pkg::axi_addr_t cfg_stride,
	output layer_pkg::dim_t        cfg_cols,
	output logic                   stream_go,
	output layer_pkg::dim_t        window_layer,
	output logic                   read_done
);
	import axi_read_pkg::*;
	import layer_pkg::*;

	seq_state_t state;
	dim_t       cfg_layers;
	dim_t       cfg_rows;
	dim_t       layer_cnt;
	dim_t       row_cnt;
	row_slot_t  slot_cnt;
	logic       last_layer;
	logic       last_row;

	// ------------------------------------------------------
	// configuration latch
	// ------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == SEQ_IDLE && start) begin
			cfg_base   <= base_addr;
			cfg_stride <= row_stride;
			cfg_layers <= num_layers;
			cfg_rows   <= num_rows;
			cfg_cols   <= num_cols;
		end
	end

	assign last_layer = (layer_cnt == cfg_layers - dim_t'(1));
	assign last_row   = (row_cnt == cfg_rows - dim_t'(1));

	// ------------------------------------------------------
	// row / layer / slot walk
	// ------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= SEQ_IDLE;
			layer_cnt <= '0;
			row_cnt   <= '0;
			slot_cnt  <= '0;
			fetch_req <= 1'b0;
			stream_go <= 1'b0;
		end else begin
			fetch_req <= 1'b0;
			stream_go <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (start) begin
						layer_cnt <= '0;
						row_cnt   <= '0;
						slot_cnt  <= '0;
						fetch_req <= 1'b1;
						state     <= SEQ_FETCH;
					end
				end
				SEQ_FETCH: begin
					if (fetch_done) begin
						if (slot_cnt == 2'd2) begin
							stream_go <= 1'b1;
							state     <= SEQ_STREAM;
						end else begin
							slot_cnt  <= slot_cnt + 2'd1;
							fetch_req <= 1'b1;
						end
					end
				end
				SEQ_STREAM: begin
					if (row_streamed) begin
						slot_cnt <= '0;
						if (!last_layer) begin
							layer_cnt <= layer_cnt + dim_t'(1);
							fetch_req <= 1'b1;
							state     <= SEQ_FETCH;
						end else if (!last_row) begin
							layer_cnt <= '0;
							row_cnt   <= row_cnt + dim_t'(1);
							fetch_req <= 1'b1;
							state     <= SEQ_FETCH;
						end else begin
							layer_cnt <= '0;
							state     <= SEQ_FINISH;
						end
					end
				end
				SEQ_FINISH: state <= SEQ_IDLE;
				default:    state <= SEQ_IDLE;
			endcase
		end
	end

	// source row is current row + slot - 1; wraps below zero and is padded
	assign fetch_layer  = layer_cnt;
	assign fetch_slot   = slot_cnt;
	assign fetch_row    = row_cnt + dim_t'(slot_cnt) - dim_t'(1);
	assign fetch_pad    = (slot_cnt == 2'd0 && row_cnt == '0) ||
	                      (slot_cnt == 2'd2 && last_row);
	assign window_layer = layer_cnt;

	// single cycle after the last row_streamed
	assign read_done = (state == SEQ_FINISH);

endmodule

/* hdl/layer_pkg.sv */
// ----------------------------------------------------------
// feature map, window and FSM types
// window byte 3i+j is window row i, column j (row-major,
// byte 0 top-left)
// ----------------------------------------------------------
`include "input_layer_cfg.svh"

package layer_pkg;

	// layer, row and column counts
	typedef logic [`DIM_WIDTH-1:0] dim_t;

	typedef logic [7:0] pixel_t;

	// 3x3 window of pixels
	typedef logic [9*8-1:0] window_t;

	// 0 above, 1 centre, 2 below
	typedef logic [1:0] row_slot_t;

	typedef logic [$clog2(`MAX_ROW_BEATS)-1:0] beat_idx_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_STREAM,
		SEQ_FINISH
	} seq_state_t;

	typedef enum logic [1:0] {
		FET_IDLE,
		FET_ADDR,
		FET_DATA,
		FET_ZERO
	} fetch_state_t;

endpackage

/* hdl/axi_read_pkg.sv */
// ----------------------------------------------------------
// AXI read bus types
// only address, length and data are carried; the bus is
// fixed to incrementing bursts of full 16-byte beats
// ----------------------------------------------------------
`include "input_layer_cfg.svh"

package axi_read_pkg;

	// byte address
	typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;

	// one read beat
	typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;

	// burst length minus one
	typedef logic [7:0] axi_len_t;

endpackage

/* include/input_layer_cfg.svh */
// ----------------------------------------------------------
// build constants for the input layer window streamer
// a row is at most MAX_ROW_BEATS beats of BEAT_BYTES bytes
// each layer sits in its own 2**LAYER_SHIFT byte block
// ----------------------------------------------------------
`ifndef INPUT_LAYER_CFG_SVH
`define INPUT_LAYER_CFG_SVH

// read bus
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 128
`define BEAT_BYTES     16

// feature map geometry
`define MAX_ROW_BEATS  4
`define LAYER_SHIFT    12
`define DIM_WIDTH      10

`endif
